/* common/mm_settings.svh */
`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// Array geometry, height is also the output buffer depth in rows
`define MM_HEIGHT 4
`define MM_WIDTH 4
// Element width in bits
`define MM_DW 16

// Register file geometry
`define MM_AW 3
`define MM_NREGS 5

// Register map
`define MM_REG_M 0
`define MM_REG_N 1
`define MM_REG_K 2
`define MM_REG_CMD 3
`define MM_REG_STATUS 4

// Command codes written to MM_REG_CMD
`define MM_CMD_START 1
`define MM_CMD_CLEAR 2

`endif

/* common/mm_pkg.sv */
`include "mm_settings.svh"

package mm_pkg;

  // Matrix dimension as written by software
  typedef logic [15:0] dim_t;

  // Iteration and tile counts
  typedef logic [15:0] iter_t;

  // One result row, MM_WIDTH elements packed side by side
  typedef logic [`MM_WIDTH*`MM_DW-1:0] row_t;

  // Peripheral register index and data word
  typedef logic [`MM_AW-1:0] reg_addr_t;
  typedef logic [31:0]       reg_data_t;

  // Controller phases
  typedef enum logic [2:0] {
    IDLE,
    STARTING,
    COMPUTING,
    BUFFERING,
    STORING,
    FINISHED
  } ctrl_state_t;

endpackage : mm_pkg

/* design/mm_regfile.sv */
`timescale 1ns/1ns
`include "mm_settings.svh"

module mm_regfile (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Peripheral request strobes
  input  logic              req_i,
  input  logic              we_i,
  input  mm_pkg::reg_addr_t addr_i,
  input  mm_pkg::reg_data_t wdata_i,
  output mm_pkg::reg_data_t rdata_o,
  output logic              rvalid_o,
  // Job status from the controller
  input  logic              done_i,
  input  logic              busy_i,
  // Job configuration and commands
  output mm_pkg::dim_t      m_o,
  output mm_pkg::dim_t      n_o,
  output mm_pkg::dim_t      k_o,
  output logic              start_o,
  output logic              clear_o,
  output logic              done_evt_o
);
  import mm_pkg::*;

  logic      addr_ok;
  logic      wr_en;
  logic      rd_en;
  logic      status_rd;
  logic      done_sticky_q;
  dim_t      m_q;
  dim_t      n_q;
  dim_t      k_q;
  reg_data_t rdata_d;
  reg_data_t rdata_q;
  logic      rvalid_q;

  // Writes outside the implemented registers are dropped
  assign addr_ok   = (addr_i < `MM_NREGS);
  assign wr_en     = req_i & we_i & addr_ok;
  assign rd_en     = req_i & ~we_i;
  assign status_rd = rd_en && (addr_i == reg_addr_t'(`MM_REG_STATUS));

  // Command pulses last as long as the write strobe
  assign start_o = wr_en && (addr_i == reg_addr_t'(`MM_REG_CMD))
                   && (wdata_i == reg_data_t'(`MM_CMD_START));
  assign clear_o = wr_en && (addr_i == reg_addr_t'(`MM_REG_CMD))
                   && (wdata_i == reg_data_t'(`MM_CMD_CLEAR));

  // Size registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_q <= '0;
      n_q <= '0;
      k_q <= '0;
    end else if (wr_en) begin
      case (addr_i)
        reg_addr_t'(`MM_REG_M): m_q <= dim_t'(wdata_i);
        reg_addr_t'(`MM_REG_N): n_q <= dim_t'(wdata_i);
        reg_addr_t'(`MM_REG_K): k_q <= dim_t'(wdata_i);
        default: ;
      endcase
    end
  end

  // A new done wins over a status read in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_sticky_q <= 1'b0;
    end else if (done_i) begin
      done_sticky_q <= 1'b1;
    end else if (clear_o || status_rd) begin
      done_sticky_q <= 1'b0;
    end
  end

  // Command register reads as zero
  always_comb begin
    rdata_d = '0;
    case (addr_i)
      reg_addr_t'(`MM_REG_M):      rdata_d = reg_data_t'(m_q);
      reg_addr_t'(`MM_REG_N):      rdata_d = reg_data_t'(n_q);
      reg_addr_t'(`MM_REG_K):      rdata_d = reg_data_t'(k_q);
      reg_addr_t'(`MM_REG_STATUS): rdata_d = reg_data_t'({done_sticky_q, busy_i});
      default:                     rdata_d = '0;
    endcase
  end

  // Response one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o    = rdata_q;
  assign rvalid_o   = rvalid_q;
  assign m_o        = m_q;
  assign n_o        = n_q;
  assign k_o        = k_q;
  // Single job event line
  assign done_evt_o = done_i;

  // Done only comes from a running job
  a_done_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |-> busy_i
  );

endmodule : mm_regfile

/* design/mm_tiler.sv */
`timescale 1ns/1ns
`include "mm_settings.svh"

module mm_tiler (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          start_i,
  input  logic          setback_i,
  input  mm_pkg::dim_t  m_i,
  input  mm_pkg::dim_t  n_i,
  input  mm_pkg::dim_t  k_i,
  output logic          cfg_valid_o,
  output mm_pkg::iter_t w_iters_o,
  output mm_pkg::iter_t tot_tiles_o
);
  import mm_pkg::*;

  // Division by shift, valid only for power of two geometry
  localparam int unsigned h_shift = $clog2(`MM_HEIGHT);
  localparam int unsigned w_shift = $clog2(`MM_WIDTH);

  logic [16:0] k_sum;
  logic [16:0] m_sum;
  logic [16:0] n_sum;
  iter_t       m_tiles;
  iter_t       n_tiles;
  iter_t       w_iters_q;
  iter_t       tot_tiles_q;
  logic        cfg_valid_q;

  // Round up by adding divisor minus one before the shift
  assign k_sum   = {1'b0, k_i} + 17'(`MM_HEIGHT - 1);
  assign m_sum   = {1'b0, m_i} + 17'(`MM_HEIGHT - 1);
  assign n_sum   = {1'b0, n_i} + 17'(`MM_WIDTH - 1);
  assign m_tiles = iter_t'(m_sum >> h_shift);
  assign n_tiles = iter_t'(n_sum >> w_shift);

  // A start loads new counts, setback only drops valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_valid_q <= 1'b0;
      w_iters_q   <= '0;
      tot_tiles_q <= '0;
    end else if (clear_i) begin
      cfg_valid_q <= 1'b0;
    end else if (start_i) begin
      cfg_valid_q <= 1'b1;
      w_iters_q   <= iter_t'(k_sum >> h_shift);
      tot_tiles_q <= iter_t'(m_tiles * n_tiles);
    end else if (setback_i) begin
      cfg_valid_q <= 1'b0;
    end
  end

  assign cfg_valid_o = cfg_valid_q;
  assign w_iters_o   = w_iters_q;
  assign tot_tiles_o = tot_tiles_q;

  // Geometry has to stay a power of two, also for the buffer pointer wrap
  a_pow2_geom: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((`MM_HEIGHT & (`MM_HEIGHT - 1)) == 0) && ((`MM_WIDTH & (`MM_WIDTH - 1)) == 0)
  );

endmodule : mm_tiler

/* mm_ctrl/mm_ctrl.sv */
`timescale 1ns/1ns

module mm_ctrl (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  // Configuration from the tiler
  input  logic          cfg_valid_i,
  input  mm_pkg::iter_t w_iters_i,
  input  mm_pkg::iter_t tot_tiles_i,
  // Engine strobes
  input  logic          w_loaded_i,
  input  logic          reg_enable_i,
  // Output buffer flags
  input  logic          z_full_i,
  input  logic          z_empty_i,
  // Control outputs
  output logic          setback_o,
  output logic          busy_o,
  output logic          done_o,
  output logic          accumulate_o,
  output logic          flush_o,
  output logic          z_fill_o
);
  import mm_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  // Result iterations within the current tile
  iter_t       iter_q;
  iter_t       iter_d;
  // Tiles stored so far
  iter_t       tile_q;
  iter_t       tile_d;

  // Clear drops state and counters back to idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      iter_q  <= '0;
      tile_q  <= '0;
    end else if (clear_i) begin
      state_q <= IDLE;
      iter_q  <= '0;
      tile_q  <= '0;
    end else begin
      state_q <= state_d;
      iter_q  <= iter_d;
      tile_q  <= tile_d;
    end
  end

  always_comb begin
    state_d   = state_q;
    iter_d    = iter_q;
    tile_d    = tile_q;
    setback_o = 1'b0;
    done_o    = 1'b0;
    flush_o   = 1'b0;
    z_fill_o  = 1'b0;

    case (state_q)
      IDLE: begin
        iter_d = '0;
        tile_d = '0;
        // Consume the tiler configuration
        if (cfg_valid_i) begin
          setback_o = 1'b1;
          state_d   = STARTING;
        end
      end

      STARTING: begin
        // Wait for the first weight row
        if (w_loaded_i) begin
          state_d = COMPUTING;
        end
      end

      COMPUTING: begin
        if (reg_enable_i) begin
          // Last iteration of the tile
          if (iter_q == w_iters_i - iter_t'(1)) begin
            iter_d  = '0;
            state_d = BUFFERING;
          end else begin
            iter_d = iter_q + iter_t'(1);
          end
        end
      end

      BUFFERING: begin
        // Every result row goes into the buffer until it reports full
        z_fill_o = reg_enable_i;
        if (z_full_i) begin
          state_d = STORING;
        end
      end

      STORING: begin
        // Buffer drained means one tile stored
        if (z_empty_i) begin
          tile_d = tile_q + iter_t'(1);
          if (tile_q == tot_tiles_i - iter_t'(1)) begin
            state_d = FINISHED;
          end else begin
            state_d = COMPUTING;
          end
        end
      end

      FINISHED: begin
        done_o  = 1'b1;
        flush_o = 1'b1;
        tile_d  = '0;
        state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  // Busy stays high through FINISHED and falls one cycle later
  assign busy_o       = (state_q != IDLE);
  // Only the first result iteration of a tile starts from zero
  assign accumulate_o = (state_q == COMPUTING) && (iter_q != '0);

  // A zero count would wrap the last iteration and last tile compares
  a_cfg_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((state_q == IDLE) && cfg_valid_i) |-> ((w_iters_i != '0) && (tot_tiles_i != '0))
  );

  // The buffer is drained before a tile computes
  a_compute_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == COMPUTING) |-> z_empty_i
  );

endmodule : mm_ctrl

/* design/mm_zbuffer.sv */
`timescale 1ns/1ns
`include "mm_settings.svh"

module mm_zbuffer (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  // Write side from the engine
  input  logic         fill_i,
  input  mm_pkg::row_t z_row_i,
  // Read side to the store streamer
  input  logic         store_ready_i,
  output mm_pkg::row_t z_row_o,
  output logic         store_valid_o,
  // Level flags
  output logic         full_o,
  output logic         empty_o
);
  import mm_pkg::*;

  localparam int unsigned depth = `MM_HEIGHT;
  localparam int unsigned pw    = $clog2(depth);

  row_t          mem_q [depth];
  logic [pw-1:0] wptr_q;
  logic [pw-1:0] rptr_q;
  logic [pw:0]   count_q;
  logic          push;
  logic          pop;
  row_t          z_row_q;
  logic          store_valid_q;

  assign full_o  = (count_q == (pw+1)'(depth));
  assign empty_o = (count_q == '0);
  // Fills on full and requests on empty are dropped
  assign push    = fill_i & ~full_o;
  assign pop     = store_ready_i & ~empty_o;

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q        <= '0;
      rptr_q        <= '0;
      count_q       <= '0;
      store_valid_q <= 1'b0;
    end else if (clear_i) begin
      wptr_q        <= '0;
      rptr_q        <= '0;
      count_q       <= '0;
      store_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      // Row is presented the cycle after the request
      store_valid_q <= pop;
    end
  end

  // Row storage and output register
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= z_row_i;
    end
    if (pop) begin
      z_row_q <= mem_q[rptr_q];
    end
  end

  assign z_row_o       = z_row_q;
  assign store_valid_o = store_valid_q;

  // Controller stops filling once full, so a lost row is a sequencing bug
  a_no_fill_on_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill_i |-> !full_o
  );

endmodule : mm_zbuffer

/* design/mm_top.sv */
`timescale 1ns/1ns

module mm_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Peripheral port
  input  logic              req_i,
  input  logic              we_i,
  input  mm_pkg::reg_addr_t addr_i,
  input  mm_pkg::reg_data_t wdata_i,
  output mm_pkg::reg_data_t rdata_o,
  output logic              rvalid_o,
  // Engine side
  input  logic              w_loaded_i,
  input  logic              reg_enable_i,
  input  mm_pkg::row_t      z_row_i,
  output logic              accumulate_o,
  output logic              flush_o,
  output logic              z_fill_o,
  // Store side
  input  logic              store_ready_i,
  output mm_pkg::row_t      z_row_o,
  output logic              store_valid_o,
  // Job status
  output logic              busy_o,
  output logic              done_evt_o
);
  import mm_pkg::*;

  dim_t  m;
  dim_t  n;
  dim_t  k;
  logic  start;
  logic  clear;
  logic  setback;
  logic  cfg_valid;
  iter_t w_iters;
  iter_t tot_tiles;
  logic  done;
  logic  z_full;
  logic  z_empty;

  mm_regfile i_regfile (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .req_i      ( req_i      ),
    .we_i       ( we_i       ),
    .addr_i     ( addr_i     ),
    .wdata_i    ( wdata_i    ),
    .rdata_o    ( rdata_o    ),
    .rvalid_o   ( rvalid_o   ),
    .done_i     ( done       ),
    .busy_i     ( busy_o     ),
    .m_o        ( m          ),
    .n_o        ( n          ),
    .k_o        ( k          ),
    .start_o    ( start      ),
    .clear_o    ( clear      ),
    .done_evt_o ( done_evt_o )
  );

  mm_tiler i_tiler (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_i     ( clear     ),
    .start_i     ( start     ),
    .setback_i   ( setback   ),
    .m_i         ( m         ),
    .n_i         ( n         ),
    .k_i         ( k         ),
    .cfg_valid_o ( cfg_valid ),
    .w_iters_o   ( w_iters   ),
    .tot_tiles_o ( tot_tiles )
  );

  mm_ctrl i_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear        ),
    .cfg_valid_i  ( cfg_valid    ),
    .w_iters_i    ( w_iters      ),
    .tot_tiles_i  ( tot_tiles    ),
    .w_loaded_i   ( w_loaded_i   ),
    .reg_enable_i ( reg_enable_i ),
    .z_full_i     ( z_full       ),
    .z_empty_i    ( z_empty      ),
    .setback_o    ( setback      ),
    .busy_o       ( busy_o       ),
    .done_o       ( done         ),
    .accumulate_o ( accumulate_o ),
    .flush_o      ( flush_o      ),
    .z_fill_o     ( z_fill_o     )
  );

  mm_zbuffer i_zbuffer (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear         ),
    .fill_i        ( z_fill_o      ),
    .z_row_i       ( z_row_i       ),
    .store_ready_i ( store_ready_i ),
    .z_row_o       ( z_row_o       ),
    .store_valid_o ( store_valid_o ),
    .full_o        ( z_full        ),
    .empty_o       ( z_empty       )
  );

endmodule : mm_top

/* test/mm_checker.sv */
`timescale 1ns/1ns
`include "mm_settings.svh"

module mm_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_i,
  input logic              we_i,
  input mm_pkg::reg_addr_t addr_i,
  input mm_pkg::reg_data_t wdata_i,
  input logic              reg_enable_i,
  input mm_pkg::row_t      z_row_i,
  input logic              accumulate_i,
  input logic              flush_i,
  input logic              z_fill_i,
  input mm_pkg::row_t      store_row_i,
  input logic              store_valid_i,
  input logic              busy_i,
  input logic              done_evt_i
);
  import mm_pkg::*;

  int   err_count = 0;
  int   err_base = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   rows_stored = 0;
  int   done_count = 0;
  int   flush_count = 0;
  int   w_exp = 1;
  int   t_exp = 0;
  int   iter_idx = 0;
  int   rows_in_tile = 0;
  int   tiles_done = 0;
  int   m_w = 0;
  int   n_w = 0;
  int   k_w = 0;
  logic cmd_wr;
  row_t exp_rows[$];

  // Expected counts straight from the matrix sizes
  function automatic void ref_counts(input int m, input int n, input int k,
                                     output int w, output int tiles);
    w     = (k + `MM_HEIGHT - 1) / `MM_HEIGHT;
    tiles = ((m + `MM_HEIGHT - 1) / `MM_HEIGHT) * ((n + `MM_WIDTH - 1) / `MM_WIDTH);
  endfunction

  // Only the first result iteration of a tile starts a fresh sum
  function automatic logic exp_accumulate(input int idx);
    return (idx != 0);
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    err_count++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count > err_base) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_count - err_base);
    end else begin
      $display("test %s: ok", name);
    end
    err_base = err_count;
  endtask

  task automatic print_summary();
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d rows stored",
             tests_run, tests_failed, err_count, rows_stored);
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cmd_wr = req_i && we_i && (addr_i == reg_addr_t'(`MM_REG_CMD));
      // Shadow copy of the size registers
      if (req_i && we_i) begin
        case (addr_i)
          reg_addr_t'(`MM_REG_M): m_w = int'(wdata_i[15:0]);
          reg_addr_t'(`MM_REG_N): n_w = int'(wdata_i[15:0]);
          reg_addr_t'(`MM_REG_K): k_w = int'(wdata_i[15:0]);
          default: ;
        endcase
      end
      if (cmd_wr && (wdata_i == `MM_CMD_START)) begin
        ref_counts(m_w, n_w, k_w, w_exp, t_exp);
        iter_idx     = 0;
        rows_in_tile = 0;
        tiles_done   = 0;
      end
      // Clear throws away everything in flight
      if (cmd_wr && (wdata_i == `MM_CMD_CLEAR)) begin
        exp_rows.delete();
        iter_idx     = 0;
        rows_in_tile = 0;
        tiles_done   = 0;
      end
      // Result iteration of the compute phase
      if (reg_enable_i && busy_i && !z_fill_i) begin
        check_value("accumulate_o", accumulate_i, exp_accumulate(iter_idx));
        iter_idx = (w_exp > 0) ? (iter_idx + 1) % w_exp : 0;
      end
      if (z_fill_i) begin
        if (!busy_i) begin
          report_error("z_fill_o went high while the controller was idle");
        end
        exp_rows.push_back(z_row_i);
      end
      if (store_valid_i) begin
        if (exp_rows.size() == 0) begin
          report_error("a row was stored while no row was buffered");
        end else begin
          check_value("z_row_o", store_row_i, exp_rows.pop_front());
        end
        rows_stored++;
        rows_in_tile++;
        if (rows_in_tile == `MM_HEIGHT) begin
          tiles_done++;
          rows_in_tile = 0;
        end
      end
      if (flush_i) begin
        flush_count++;
      end
      if (done_evt_i) begin
        done_count++;
        check_value("flush_o", flush_i, 1'b1);
        check_value("tiles stored", tiles_done, t_exp);
        if (exp_rows.size() != 0) begin
          report_error("the job ended with buffered rows never stored");
        end
      end
    end
  end

endmodule : mm_checker

/* test/tb_mm_top.sv */
`timescale 1ns/1ns
`include "mm_settings.svh"

module tb_mm_top;
  import mm_pkg::*;

  logic      clk_i;
  logic      rst_ni;
  logic      req_i;
  logic      we_i;
  reg_addr_t addr_i;
  reg_data_t wdata_i;
  reg_data_t rdata_o;
  logic      rvalid_o;
  logic      w_loaded_i;
  logic      reg_enable_i;
  row_t      z_row_i;
  logic      accumulate_o;
  logic      flush_o;
  logic      z_fill_o;
  logic      store_ready_i;
  row_t      z_row_o;
  logic      store_valid_o;
  logic      busy_o;
  logic      done_evt_o;

  integer    seed = 32'h55b5_9af9;
  int        cycles = 0;
  int        limit = 0;
  // The first three jobs give K of 4, 7 and 16 and the fourth is cleared
  int        jm[5] = '{8, 5, 4, 8, 4};
  int        jn[5] = '{4, 6, 8, 8, 4};
  int        jk[5] = '{4, 7, 16, 8, 4};

  mm_top i_mm_top (.*);

  mm_checker i_checker (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .req_i         ( req_i         ),
    .we_i          ( we_i          ),
    .addr_i        ( addr_i        ),
    .wdata_i       ( wdata_i       ),
    .reg_enable_i  ( reg_enable_i  ),
    .z_row_i       ( z_row_i       ),
    .accumulate_i  ( accumulate_o  ),
    .flush_i       ( flush_o       ),
    .z_fill_i      ( z_fill_o      ),
    .store_row_i   ( z_row_o       ),
    .store_valid_i ( store_valid_o ),
    .busy_i        ( busy_o        ),
    .done_evt_i    ( done_evt_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run limit is set once the job list is known
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic reg_write(input int addr, input int data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= reg_addr_t'(addr);
    wdata_i <= reg_data_t'(data);
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  // Response is due exactly one cycle after the request
  task automatic reg_read(input int addr, output reg_data_t data);
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= reg_addr_t'(addr);
    @(posedge clk_i);
    req_i <= 1'b0;
    @(posedge clk_i);
    if (!rvalid_o) begin
      i_checker.report_error("no read response one cycle after the request");
    end
    data = rdata_o;
  endtask

  task automatic pulse_enable();
    @(posedge clk_i);
    reg_enable_i <= 1'b1;
    z_row_i      <= {$random(seed), $random(seed)};
    @(posedge clk_i);
    reg_enable_i <= 1'b0;
  endtask

  task automatic pulse_store();
    @(posedge clk_i);
    store_ready_i <= 1'b1;
    @(posedge clk_i);
    store_ready_i <= 1'b0;
  endtask

  task automatic pulse_loaded();
    @(posedge clk_i);
    w_loaded_i <= 1'b1;
    @(posedge clk_i);
    w_loaded_i <= 1'b0;
  endtask

  // Engine model for one tile gives results and buffer fills and then drains with random gaps
  task automatic run_tile(input int w);
    for (int i = 0; i < w + `MM_HEIGHT; i++) pulse_enable();
    repeat (3) @(posedge clk_i);
    for (int i = 0; i < `MM_HEIGHT; i++) begin
      repeat ($unsigned($random(seed)) % 3) @(posedge clk_i);
      pulse_store();
    end
    repeat (3) @(posedge clk_i);
  endtask

  task automatic start_job(input int j);
    reg_write(`MM_REG_M, jm[j]);
    reg_write(`MM_REG_N, jn[j]);
    reg_write(`MM_REG_K, jk[j]);
    reg_write(`MM_REG_CMD, `MM_CMD_START);
    while (!busy_o) @(posedge clk_i);
    pulse_loaded();
  endtask

  task automatic run_job(input int j);
    int w;
    int tiles;
    int done_before;
    done_before = i_checker.done_count;
    i_checker.ref_counts(jm[j], jn[j], jk[j], w, tiles);
    start_job(j);
    for (int t = 0; t < tiles; t++) run_tile(w);
    while (busy_o) @(posedge clk_i);
    i_checker.check_value("done_evt_o count", i_checker.done_count - done_before, 1);
  endtask

  initial begin
    reg_data_t rd;
    int        w;
    int        tiles;
    int        stored;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    w_loaded_i    = 1'b0;
    reg_enable_i  = 1'b0;
    z_row_i       = '0;
    store_ready_i = 1'b0;
    for (int j = 0; j < 5; j++) begin
      i_checker.ref_counts(jm[j], jn[j], jk[j], w, tiles);
      limit += (w + `MM_HEIGHT) * tiles * 20;
    end
    limit += 2000;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Outputs idle after reset and sizes read back unchanged
    @(posedge clk_i);
    i_checker.check_value("idle outputs",
      {busy_o, done_evt_o, accumulate_o, flush_o, z_fill_o, store_valid_o, rvalid_o}, 0);
    reg_write(`MM_REG_M, 16'h1234);
    reg_write(`MM_REG_N, 16'h00ab);
    reg_write(`MM_REG_K, 16'hbeef);
    reg_read(`MM_REG_M, rd);
    i_checker.check_value("m readback", rd, 32'h1234);
    reg_read(`MM_REG_N, rd);
    i_checker.check_value("n readback", rd, 32'h00ab);
    reg_read(`MM_REG_K, rd);
    i_checker.check_value("k readback", rd, 32'hbeef);
    reg_read(`MM_REG_STATUS, rd);
    i_checker.check_value("status", rd, 32'h0);
    i_checker.end_test("register access");

    // Strobes with nothing to act on
    stored = i_checker.rows_stored;
    repeat (3) pulse_store();
    repeat (3) pulse_enable();
    repeat (4) @(posedge clk_i);
    i_checker.check_value("rows stored", i_checker.rows_stored, stored);
    i_checker.end_test("ignored strobes");

    for (int j = 0; j < 3; j++) run_job(j);
    i_checker.end_test("accumulate, data order and job length");

    reg_read(`MM_REG_STATUS, rd);
    i_checker.check_value("status after jobs", rd, 32'h2);
    reg_read(`MM_REG_STATUS, rd);
    i_checker.check_value("status after read", rd, 32'h0);
    i_checker.check_value("flush_o count", i_checker.flush_count, 3);
    i_checker.end_test("done status");

    // One full tile and then a clear while the buffer is half filled
    i_checker.ref_counts(jm[3], jn[3], jk[3], w, tiles);
    start_job(3);
    run_tile(w);
    for (int i = 0; i < w + 2; i++) pulse_enable();
    reg_write(`MM_REG_CMD, `MM_CMD_CLEAR);
    repeat (2) @(posedge clk_i);
    i_checker.check_value("busy_o after clear", busy_o, 1'b0);
    stored = i_checker.rows_stored;
    repeat (2) pulse_store();
    repeat (2) pulse_enable();
    repeat (4) @(posedge clk_i);
    i_checker.check_value("rows stored after clear", i_checker.rows_stored, stored);
    run_job(4);
    i_checker.end_test("clear mid job");

    i_checker.print_summary();
    if (i_checker.err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_mm_top

/* project.f */
+incdir+common
common/mm_pkg.sv
design/mm_regfile.sv
design/mm_tiler.sv
mm_ctrl/mm_ctrl.sv
design/mm_zbuffer.sv
design/mm_top.sv
test/mm_checker.sv
test/tb_mm_top.sv
